//--- run_sim.sh
#!/bin/sh
# Build the debugger testbench with Verilator, run it, and
# pass only if the simulation prints the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sources.f --top-module tb_saturn_debugger -o sim_tb \
    && ./obj_dir/sim_tb | tee /dev/stderr | grep -q "ALL TESTS PASSED" \
    && echo "Simulation passed" \
    && exit 0 \
    || { echo "Simulation failed"; exit 1; }

//--- sources.f
src/dbg_pkg.sv
src/dump_buffer.sv
src/dump_formatter.sv
src/dump_session.sv
src/saturn_debugger.sv
verification/dump_checker.sv
verification/tb_saturn_debugger.sv

//--- src/dbg_pkg.sv
// ========================================
// Shared types for the register-dump debugger
// CPU field widths, register-select codes,
// snapshot struct, formatter field states
// and the dump text length
// ========================================

`default_nettype none

package dbg_pkg;

    // Basic CPU widths
    typedef logic [3:0]  nibble_t;   // One 4-bit digit
    typedef logic [19:0] addr_t;     // Program counter
    typedef logic [15:0] status_t;   // ST flags
    typedef logic [7:0]  char_t;     // ASCII character

    // Register numbering follows the ALU
    typedef logic [4:0]  reg_sel_t;

    localparam reg_sel_t REG_SEL_C    = 5'd2;
    localparam reg_sel_t REG_SEL_NONE = 5'd31;

    // CPU state sampled for the dump
    typedef struct packed {
        addr_t   pc;
        nibble_t p;
        nibble_t hst;
        status_t st;
    } cpu_state_t;

    // Formatter fields, in output order
    typedef enum logic [3:0] {
        FIELD_PC_LABEL,   // "PC: "
        FIELD_PC_VALUE,   // Five hex digits
        FIELD_NL_1,
        FIELD_P,          // "P: x HST: "
        FIELD_HST,        // Four binary digits
        FIELD_ST_LABEL,   // " ST: "
        FIELD_ST_VALUE,   // Sixteen binary digits
        FIELD_NL_2,
        FIELD_C_LABEL,    // "C: "
        FIELD_C_VALUE,    // Sixteen hex digits and the last newline
        FIELD_DONE
    } dump_field_e;

    // Characters in one complete dump
    //   line 1: 10
    //   line 2: 36
    //   line 3: 20
    localparam int DUMP_TEXT_LEN = 66;

endpackage

`default_nettype wire

//--- src/dump_buffer.sv
// ========================================
// Dump text memory
// One write port, one registered read port
// ========================================

`timescale 1ns/1ps
`default_nettype none

module dump_buffer #(
    parameter int BUFFER_DEPTH = 128
) (
    input  wire                             i_clk,
    input  wire                             i_wr_en,
    input  wire [$clog2(BUFFER_DEPTH)-1:0]  i_wr_addr,
    input  dbg_pkg::char_t                  i_wr_char,
    input  wire [$clog2(BUFFER_DEPTH)-1:0]  i_rd_addr,
    output dbg_pkg::char_t                  o_rd_char
);

    dbg_pkg::char_t mem [BUFFER_DEPTH];

    // Write side, driven by the formatter
    always_ff @(posedge i_clk) begin
        if (i_wr_en)
            mem[i_wr_addr] <= i_wr_char;
    end

    // Registered read, maps onto block RAM
    always_ff @(posedge i_clk) begin
        o_rd_char <= mem[i_rd_addr];
    end

endmodule

`default_nettype wire

//--- src/dump_formatter.sv
// ========================================
// Dump text formatter
// Walks the dump fields, converts digits to
// ASCII and writes one character per clock,
// reading register C through the debug port
// ========================================

`timescale 1ns/1ps
`default_nettype none

module dump_formatter #(
    parameter int BUFFER_DEPTH = 128
) (
    input  wire                    i_clk,
    input  wire                    i_reset,
    input  wire                    i_format_start,
    input  dbg_pkg::cpu_state_t    i_cpu_state,
    input  dbg_pkg::nibble_t       i_dbg_reg_nibble,
    output dbg_pkg::reg_sel_t      o_dbg_register,
    output dbg_pkg::nibble_t       o_dbg_reg_ptr,
    output logic                   o_wr_en,
    output logic [$clog2(BUFFER_DEPTH)-1:0] o_wr_addr,
    output dbg_pkg::char_t         o_wr_char,
    output logic                   o_format_done
);

    localparam int PTR_W = $clog2(BUFFER_DEPTH);

    dbg_pkg::dump_field_e field;
    logic [4:0]           pos;       // Label index or digit index
    logic [4:0]           c_index;   // C nibble, one below pos
    logic                 c_read;

    function automatic dbg_pkg::char_t hex_char(input dbg_pkg::nibble_t n);
        if (n < 4'd10)
            return 8'h30 + {4'h0, n};
        return 8'h37 + {4'h0, n};   // Upper case A-F
    endfunction

    function automatic dbg_pkg::char_t bin_char(input logic b);
        return b ? "1" : "0";
    endfunction

    // Position 0 of the C field is the closing newline
    assign c_index        = pos - 5'd1;
    assign c_read         = (field == dbg_pkg::FIELD_C_VALUE) && (pos != 5'd0);
    assign o_dbg_register = c_read ? dbg_pkg::REG_SEL_C : dbg_pkg::REG_SEL_NONE;
    assign o_dbg_reg_ptr  = c_read ? c_index[3:0] : 4'h0;
    assign o_wr_en        = (field != dbg_pkg::FIELD_DONE);

    // Character for the current field and position
    always_comb begin
        case (field)
            dbg_pkg::FIELD_PC_LABEL: begin
                case (pos)
                    5'd0:    o_wr_char = "P";
                    5'd1:    o_wr_char = "C";
                    5'd2:    o_wr_char = ":";
                    default: o_wr_char = " ";
                endcase
            end
            dbg_pkg::FIELD_PC_VALUE: o_wr_char = hex_char(i_cpu_state.pc[pos[2:0]*4 +: 4]);
            dbg_pkg::FIELD_P: begin
                case (pos)
                    5'd0:    o_wr_char = "P";
                    5'd1:    o_wr_char = ":";
                    5'd3:    o_wr_char = hex_char(i_cpu_state.p);
                    5'd5:    o_wr_char = "H";
                    5'd6:    o_wr_char = "S";
                    5'd7:    o_wr_char = "T";
                    5'd8:    o_wr_char = ":";
                    default: o_wr_char = " ";
                endcase
            end
            dbg_pkg::FIELD_HST:      o_wr_char = bin_char(i_cpu_state.hst[pos[1:0]]);
            dbg_pkg::FIELD_ST_LABEL: begin
                case (pos)
                    5'd1:    o_wr_char = "S";
                    5'd2:    o_wr_char = "T";
                    5'd3:    o_wr_char = ":";
                    default: o_wr_char = " ";
                endcase
            end
            dbg_pkg::FIELD_ST_VALUE: o_wr_char = bin_char(i_cpu_state.st[pos[3:0]]);
            dbg_pkg::FIELD_C_LABEL: begin
                case (pos)
                    5'd0:    o_wr_char = "C";
                    5'd1:    o_wr_char = ":";
                    default: o_wr_char = " ";
                endcase
            end
            dbg_pkg::FIELD_C_VALUE:  o_wr_char = c_read ? hex_char(i_dbg_reg_nibble) : "\n";
            default:                 o_wr_char = "\n";   // Both newline fields
        endcase
    end

    // Field sequencing, one character per clock
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            field         <= dbg_pkg::FIELD_DONE;
            pos           <= 5'd0;
            o_wr_addr     <= '0;
            o_format_done <= 1'b0;
        end else if (i_format_start) begin
            field         <= dbg_pkg::FIELD_PC_LABEL;
            pos           <= 5'd0;
            o_wr_addr     <= '0;
            o_format_done <= 1'b0;
        end else if (o_wr_en) begin
            o_wr_addr <= o_wr_addr + PTR_W'(1);
            case (field)
                dbg_pkg::FIELD_PC_LABEL: begin
                    if (pos == 5'd3) begin
                        field <= dbg_pkg::FIELD_PC_VALUE;
                        pos   <= 5'd4;   // Most significant digit first
                    end else begin
                        pos <= pos + 5'd1;
                    end
                end
                dbg_pkg::FIELD_PC_VALUE: begin
                    if (pos == 5'd0)
                        field <= dbg_pkg::FIELD_NL_1;
                    else
                        pos <= pos - 5'd1;
                end
                dbg_pkg::FIELD_NL_1: field <= dbg_pkg::FIELD_P;
                dbg_pkg::FIELD_P: begin
                    if (pos == 5'd9) begin
                        field <= dbg_pkg::FIELD_HST;
                        pos   <= 5'd3;
                    end else begin
                        pos <= pos + 5'd1;
                    end
                end
                dbg_pkg::FIELD_HST: begin
                    if (pos == 5'd0)
                        field <= dbg_pkg::FIELD_ST_LABEL;
                    else
                        pos <= pos - 5'd1;
                end
                dbg_pkg::FIELD_ST_LABEL: begin
                    if (pos == 5'd4) begin
                        field <= dbg_pkg::FIELD_ST_VALUE;
                        pos   <= 5'd15;
                    end else begin
                        pos <= pos + 5'd1;
                    end
                end
                dbg_pkg::FIELD_ST_VALUE: begin
                    if (pos == 5'd0)
                        field <= dbg_pkg::FIELD_NL_2;
                    else
                        pos <= pos - 5'd1;
                end
                dbg_pkg::FIELD_NL_2: field <= dbg_pkg::FIELD_C_LABEL;
                dbg_pkg::FIELD_C_LABEL: begin
                    if (pos == 5'd2) begin
                        field <= dbg_pkg::FIELD_C_VALUE;
                        pos   <= 5'd16;   // Nibble 15 down, then newline
                    end else begin
                        pos <= pos + 5'd1;
                    end
                end
                dbg_pkg::FIELD_C_VALUE: begin
                    if (pos == 5'd0) begin
                        field         <= dbg_pkg::FIELD_DONE;
                        o_format_done <= 1'b1;
                    end else begin
                        pos <= pos - 5'd1;
                    end
                end
                default: field <= dbg_pkg::FIELD_DONE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/dump_session.sv
// ========================================
// Debug-cycle control and character streamer
// Trigger detect, format handoff and
// one character per enabled clock
// ========================================

`timescale 1ns/1ps
`default_nettype none

module dump_session #(
    parameter int BUFFER_DEPTH = 128
) (
    input  wire                             i_clk,
    input  wire                             i_reset,
    input  wire                             i_clk_en,
    input  wire [3:0]                       i_phases,
    input  wire                             i_instr_decoded,
    input  wire                             i_format_done,
    input  dbg_pkg::char_t                  i_rd_char,
    output logic                            o_format_start,
    output logic [$clog2(BUFFER_DEPTH)-1:0] o_rd_addr,
    output logic                            o_debug_cycle,
    output dbg_pkg::char_t                  o_char_to_send,
    output logic                            o_char_strobe
);

    localparam int PTR_W = $clog2(BUFFER_DEPTH);

    typedef enum logic [2:0] {
        SES_IDLE,
        SES_START,    // Formatter start pulse
        SES_FORMAT,   // Wait for the text
        SES_STREAM,   // Issue reads
        SES_DRAIN     // Last character in flight
    } session_e;

    session_e         state;
    logic [PTR_W-1:0] rd_ptr;
    logic             rd_pending;   // Read data arrives this cycle
    logic             rd_last;
    logic             out_last;     // Strobed character is the final one
    logic             trigger;
    logic             last_addr;

    // Phase 3 of an enabled clock, only while idle
    assign trigger        = i_clk_en && i_phases[3] && i_instr_decoded && (state == SES_IDLE);
    assign last_addr      = (rd_ptr == PTR_W'(dbg_pkg::DUMP_TEXT_LEN - 1));
    assign o_rd_addr      = rd_ptr;
    assign o_format_start = (state == SES_START);
    assign o_debug_cycle  = (state != SES_IDLE);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state         <= SES_IDLE;
            rd_ptr        <= '0;
            rd_pending    <= 1'b0;
            rd_last       <= 1'b0;
            out_last      <= 1'b0;
            o_char_strobe <= 1'b0;
        end else begin
            rd_pending    <= 1'b0;
            rd_last       <= 1'b0;
            o_char_strobe <= rd_pending;
            out_last      <= rd_last;
            case (state)
                SES_IDLE: begin
                    rd_ptr <= '0;
                    if (trigger)
                        state <= SES_START;
                end
                SES_START:  state <= SES_FORMAT;   // Stale done is cleared by now
                SES_FORMAT: if (i_format_done) state <= SES_STREAM;
                SES_STREAM: begin
                    if (i_clk_en) begin
                        rd_pending <= 1'b1;
                        rd_last    <= last_addr;
                        rd_ptr     <= rd_ptr + PTR_W'(1);
                        if (last_addr)
                            state <= SES_DRAIN;
                    end
                end
                SES_DRAIN: if (o_char_strobe && out_last) state <= SES_IDLE;
                default:   state <= SES_IDLE;
            endcase
        end
    end

    // Output character, held between strobes
    always_ff @(posedge i_clk) begin
        if (rd_pending)
            o_char_to_send <= i_rd_char;
    end

endmodule

`default_nettype wire

//--- src/saturn_debugger.sv
// ========================================
// Register-dump debugger, top level
// Session control, formatter, text buffer
// ========================================

`timescale 1ns/1ps
`default_nettype none

module saturn_debugger #(
    parameter int BUFFER_DEPTH = 128
) (
    input  wire                  i_clk,
    input  wire                  i_reset,
    input  wire                  i_clk_en,
    input  wire [3:0]            i_phases,
    input  wire                  i_instr_decoded,
    input  dbg_pkg::cpu_state_t  i_cpu_state,
    input  dbg_pkg::nibble_t     i_dbg_reg_nibble,
    output logic                 o_debug_cycle,
    output dbg_pkg::reg_sel_t    o_dbg_register,
    output dbg_pkg::nibble_t     o_dbg_reg_ptr,
    output dbg_pkg::char_t       o_char_to_send,
    output logic                 o_char_strobe
);

    localparam int PTR_W = $clog2(BUFFER_DEPTH);

    logic             format_start;
    logic             format_done;
    logic             wr_en;
    logic [PTR_W-1:0] wr_addr;
    dbg_pkg::char_t   wr_char;
    logic [PTR_W-1:0] rd_addr;
    dbg_pkg::char_t   rd_char;

    dump_session #(
        .BUFFER_DEPTH (BUFFER_DEPTH)
    ) u_session (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_clk_en        (i_clk_en),
        .i_phases        (i_phases),
        .i_instr_decoded (i_instr_decoded),
        .i_format_done   (format_done),
        .i_rd_char       (rd_char),
        .o_format_start  (format_start),
        .o_rd_addr       (rd_addr),
        .o_debug_cycle   (o_debug_cycle),
        .o_char_to_send  (o_char_to_send),
        .o_char_strobe   (o_char_strobe)
    );

    dump_formatter #(
        .BUFFER_DEPTH (BUFFER_DEPTH)
    ) u_formatter (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_format_start   (format_start),
        .i_cpu_state      (i_cpu_state),
        .i_dbg_reg_nibble (i_dbg_reg_nibble),
        .o_dbg_register   (o_dbg_register),
        .o_dbg_reg_ptr    (o_dbg_reg_ptr),
        .o_wr_en          (wr_en),
        .o_wr_addr        (wr_addr),
        .o_wr_char        (wr_char),
        .o_format_done    (format_done)
    );

    dump_buffer #(
        .BUFFER_DEPTH (BUFFER_DEPTH)
    ) u_buffer (
        .i_clk     (i_clk),
        .i_wr_en   (wr_en),
        .i_wr_addr (wr_addr),
        .i_wr_char (wr_char),
        .i_rd_addr (rd_addr),
        .o_rd_char (rd_char)
    );

endmodule

`default_nettype wire

//--- verification/dump_checker.sv
// ========================================
// Dump checker
// Rebuilds the expected dump text, compares
// each strobed character and checks the
// trigger, register-C port and dump end
// ========================================

`timescale 1ns/1ps
`default_nettype none

module dump_checker (
    input  wire                 i_clk,
    input  wire                 i_reset,
    input  wire                 i_clk_en,
    input  wire [3:0]           i_phases,
    input  wire                 i_instr_decoded,
    input  dbg_pkg::cpu_state_t i_cpu_state,
    input  wire [63:0]          i_c_value,
    input  wire                 i_test_start,
    input  wire                 i_test_end,
    input  wire [7:0]           i_test_id,
    input  wire [7:0]           i_test_mode,
    input  wire [7:0]           i_expect_dumps,
    input  wire                 i_debug_cycle,
    input  dbg_pkg::reg_sel_t   i_dbg_register,
    input  dbg_pkg::nibble_t    i_dbg_reg_ptr,
    input  dbg_pkg::char_t      i_char_to_send,
    input  wire                 i_char_strobe,
    output int                  o_tests_run,
    output int                  o_tests_failed,
    output int                  o_errors
);

    localparam int LEN = dbg_pkg::DUMP_TEXT_LEN;

    logic [7:0] exp_text [LEN];
    int   fill = 0;          // Next free slot while building
    int   idx = 0;           // Next character expected
    int   c_run = 0;         // Cycles of the current C read
    int   c_runs = 0;
    int   dumps = 0;
    int   test_errors = 0;
    logic dbg_d = 1'b0;
    logic trig_d = 1'b0;     // Trigger seen at the last sample
    logic reset_d = 1'b0;
    logic en_d1 = 1'b0;
    logic en_d2 = 1'b0;
    logic after_last = 1'b0;

    initial begin
        o_tests_run    = 0;
        o_tests_failed = 0;
        o_errors       = 0;
    end

    task automatic report_error(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        o_errors++;
        test_errors++;
    endtask

    function automatic logic [7:0] hex_ascii(input logic [3:0] n);
        string digits;
        digits = "0123456789ABCDEF";
        return digits[int'(n)];
    endfunction

    task automatic put_char(input logic [7:0] ch);
        exp_text[fill] = ch;
        fill++;
    endtask

    task automatic put_str(input string s);
        for (int k = 0; k < s.len(); k++)
            put_char(s[k]);
    endtask

    // PC line, P/HST/ST line and C line
    task automatic build_expected();
        fill = 0;
        put_str("PC: ");
        for (int i = 4; i >= 0; i--)
            put_char(hex_ascii(4'(i_cpu_state.pc >> (i * 4))));
        put_char(8'h0a);
        put_str("P: ");
        put_char(hex_ascii(i_cpu_state.p));
        put_str(" HST: ");
        for (int i = 3; i >= 0; i--)
            put_char(1'(i_cpu_state.hst >> i) ? 8'h31 : 8'h30);   // ASCII 1 or 0
        put_str(" ST: ");
        for (int i = 15; i >= 0; i--)
            put_char(1'(i_cpu_state.st >> i) ? 8'h31 : 8'h30);
        put_char(8'h0a);
        put_str("C: ");
        for (int i = 15; i >= 0; i--)
            put_char(hex_ascii(4'(i_c_value >> (i * 4))));
        put_char(8'h0a);
    endtask

    task automatic check_char();
        if (!i_debug_cycle)
            report_error("character strobe outside a debug cycle");
        else if (!en_d2)
            report_error("character strobe without an enabled clock");
        else if (idx >= LEN)
            report_error("more characters than one dump holds");
        else if (i_char_to_send != exp_text[idx])
            report_error($sformatf("char %0d is 0x%02h, expected 0x%02h",
                                   idx, i_char_to_send, exp_text[idx]));
        idx++;
        after_last = (idx == LEN);
    endtask

    // Nibble pointer must count 15 down to 0 in one run
    task automatic check_port();
        if (i_dbg_register == dbg_pkg::REG_SEL_C) begin
            if (!i_debug_cycle || c_run >= 16 || int'(i_dbg_reg_ptr) != 15 - c_run)
                report_error($sformatf("register C read with pointer %0d at step %0d",
                                       i_dbg_reg_ptr, c_run));
            c_run++;
        end else begin
            if (i_dbg_register != dbg_pkg::REG_SEL_NONE)
                report_error($sformatf("unexpected register select %0d", i_dbg_register));
            if (c_run != 0) begin
                if (c_run != 16)
                    report_error($sformatf("register C selected for %0d cycles", c_run));
                c_runs++;
                c_run = 0;
            end
        end
    endtask

    always @(negedge i_clk) begin
        if (i_test_start) begin
            test_errors = 0;
            dumps       = 0;
        end
        if (reset_d) begin
            if (i_debug_cycle || i_char_strobe || i_dbg_register != dbg_pkg::REG_SEL_NONE
                || i_dbg_reg_ptr != 4'h0)
                report_error("outputs not idle after reset");
            idx        = 0;
            c_run      = 0;
            after_last = 1'b0;
        end else begin
            if (trig_d && !(i_debug_cycle && !dbg_d))
                report_error("valid trigger did not start a dump");
            if (!trig_d && i_debug_cycle && !dbg_d)
                report_error("dump started without a valid trigger");
            if (after_last && i_debug_cycle)
                report_error("debug cycle still high after the last character");
            if (i_debug_cycle && !dbg_d) begin
                build_expected();
                idx    = 0;
                c_runs = 0;
            end
            after_last = 1'b0;
            if (i_char_strobe)
                check_char();
            check_port();
            if (!i_debug_cycle && dbg_d) begin
                if (idx != LEN || c_runs != 1)
                    report_error($sformatf("dump ended after %0d characters, %0d C reads",
                                           idx, c_runs));
                else
                    dumps++;
            end
        end
        if (i_test_end) begin
            o_tests_run++;
            if (test_errors == 0 && dumps == int'(i_expect_dumps) && !i_debug_cycle) begin
                $display("Test %0d (mode %0d): passed, %0d dump(s)",
                         i_test_id, i_test_mode, dumps);
            end else begin
                o_tests_failed++;
                $display("Test %0d (mode %0d): failed, %0d of %0d dump(s), %0d error(s)",
                         i_test_id, i_test_mode, dumps, i_expect_dumps, test_errors);
            end
        end
        dbg_d   = i_debug_cycle;
        trig_d  = i_clk_en && i_phases[3] && i_instr_decoded && !i_debug_cycle && !i_reset;
        reset_d = i_reset;
        en_d2   = en_d1;
        en_d1   = i_clk_en;
    end

endmodule

`default_nettype wire

//--- verification/dump_vectors.txt
// Columns, hex: mode pc p hst st c ; a line of zeros ends the list
// Mode 1 enable high, 2 random enable, 3 bad triggers, 4 retrigger, 5 reset mid-dump
1 12345 A 5 8001 0123456789ABCDEF
1 FFFFF F F FFFF FEDCBA9876543210
1 00000 0 0 0000 0000000000000000
2 0A5C3 7 9 5AA5 DEADBEEFCAFEF00D
2 80001 1 2 1234 13579BDF02468ACE
3 11111 2 3 4444 5555666677778888
4 3C3C3 C 6 F00F 0F1E2D3C4B5A6978
5 6789A 4 A 0FF0 8899AABBCCDDEEFF
0 0 0 0 0 0

//--- verification/tb_saturn_debugger.sv
// ========================================
// Testbench for the register-dump debugger
// Clock, reset, register C model, vector
// stimulus, LCG clock enable, timeout
// ========================================

`timescale 1ns/1ps
`default_nettype none

module tb_saturn_debugger;

    localparam int BUFFER_DEPTH = 128;
    localparam int MAX_TESTS    = 16;
    localparam int TEST_CYCLES  = dbg_pkg::DUMP_TEXT_LEN * 8 + 100;

    logic                i_clk = 1'b0;
    logic                i_reset;
    logic                i_clk_en;
    logic [3:0]          i_phases;
    logic                i_instr_decoded;
    dbg_pkg::cpu_state_t i_cpu_state;
    dbg_pkg::nibble_t    i_dbg_reg_nibble;
    logic                o_debug_cycle;
    dbg_pkg::reg_sel_t   o_dbg_register;
    dbg_pkg::nibble_t    o_dbg_reg_ptr;
    dbg_pkg::char_t      o_char_to_send;
    logic                o_char_strobe;

    logic [63:0] c_value;
    logic [63:0] vec_mem [6 * MAX_TESTS];   // Six words per test
    logic        test_start;
    logic        test_end;
    logic [7:0]  test_id;
    logic [7:0]  test_mode;
    logic [7:0]  expect_dumps;
    logic        random_en;
    logic [31:0] lcg_state;
    int          num_tests;
    int          cycle_count = 0;
    int          cycle_limit = 0;
    int          tests_run;
    int          tests_failed;
    int          error_count;

    always #2 i_clk = ~i_clk;

    // CPU side of the register read port
    assign i_dbg_reg_nibble = (o_dbg_register == dbg_pkg::REG_SEL_C) ?
                              c_value[{o_dbg_reg_ptr, 2'b00} +: 4] : 4'h0;

    saturn_debugger #(.BUFFER_DEPTH(BUFFER_DEPTH)) uut (.*);

    dump_checker u_checker (
        .i_clk (i_clk), .i_reset (i_reset), .i_clk_en (i_clk_en), .i_phases (i_phases),
        .i_instr_decoded (i_instr_decoded), .i_cpu_state (i_cpu_state),
        .i_c_value (c_value), .i_test_start (test_start), .i_test_end (test_end),
        .i_test_id (test_id), .i_test_mode (test_mode), .i_expect_dumps (expect_dumps),
        .i_debug_cycle (o_debug_cycle), .i_dbg_register (o_dbg_register),
        .i_dbg_reg_ptr (o_dbg_reg_ptr), .i_char_to_send (o_char_to_send),
        .i_char_strobe (o_char_strobe), .o_tests_run (tests_run),
        .o_tests_failed (tests_failed), .o_errors (error_count)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // One clock, inputs change 1 ns after the edge
    task automatic step();
        @(posedge i_clk);
        #1;
        if (random_en) begin
            lcg_state = lcg_next(lcg_state);
            i_clk_en  = (lcg_state[31:30] != 2'b00);   // About three in four
        end else begin
            i_clk_en = 1'b1;
        end
    endtask

    task automatic pulse_trigger(input logic [3:0] phases, input logic en);
        i_phases        = phases;
        i_instr_decoded = 1'b1;
        i_clk_en        = en;
        step();
        i_phases        = 4'b0001;
        i_instr_decoded = 1'b0;
    endtask

    task automatic await_dump();
        while (!o_debug_cycle)
            step();
    endtask

    task automatic finish_dump();
        while (o_debug_cycle)
            step();
    endtask

    task automatic count_strobes(input int n);
        int seen;
        seen = 0;
        while (seen < n) begin
            step();
            if (o_char_strobe)
                seen++;
        end
    endtask

    task automatic run_test(input int t);
        logic [7:0] mode;
        int         base;
        base                = 6 * t;
        mode                = vec_mem[base][7:0];
        i_cpu_state.pc      = vec_mem[base + 1][19:0];
        i_cpu_state.p       = vec_mem[base + 2][3:0];
        i_cpu_state.hst     = vec_mem[base + 3][3:0];
        i_cpu_state.st      = vec_mem[base + 4][15:0];
        c_value             = vec_mem[base + 5];
        test_id             = 8'(t + 1);
        test_mode           = mode;
        expect_dumps        = (mode == 8'd3) ? 8'd0 : 8'd1;
        random_en           = (mode == 8'd2);
        test_start          = 1'b1;
        step();
        test_start          = 1'b0;
        case (mode)
            8'd3: begin                      // No phase 3, then clock enable low
                pulse_trigger(4'b0100, 1'b1);
                repeat (8) step();
                pulse_trigger(4'b1000, 1'b0);
                repeat (8) step();
            end
            8'd4: begin                      // Retrigger while formatting and streaming
                pulse_trigger(4'b1000, 1'b1);
                repeat (12) step();
                pulse_trigger(4'b1000, 1'b1);
                count_strobes(10);
                pulse_trigger(4'b1000, 1'b1);
                finish_dump();
                repeat (8) step();
            end
            8'd5: begin                      // Reset in the middle of streaming
                pulse_trigger(4'b1000, 1'b1);
                count_strobes(20);
                i_reset = 1'b1;
                repeat (2) step();
                i_reset = 1'b0;
                repeat (3) step();
                pulse_trigger(4'b1000, 1'b1);
                await_dump();
                finish_dump();
            end
            default: begin
                pulse_trigger(4'b1000, 1'b1);
                await_dump();
                finish_dump();
            end
        endcase
        random_en = 1'b0;
        repeat (3) step();
        test_end = 1'b1;
        step();
        test_end = 1'b0;
    endtask

    always @(posedge i_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not end within %0d clock cycles", cycle_limit);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial begin
        i_reset         = 1'b1;
        i_clk_en        = 1'b0;
        i_phases        = 4'b0001;
        i_instr_decoded = 1'b0;
        i_cpu_state     = '0;
        c_value         = '0;
        test_start      = 1'b0;
        test_end        = 1'b0;
        test_id         = 8'd0;
        test_mode       = 8'd0;
        expect_dumps    = 8'd0;
        random_en       = 1'b0;
        lcg_state       = 32'ha03a_d732;
        $readmemh("verification/dump_vectors.txt", vec_mem);
        num_tests = 0;
        while (num_tests < MAX_TESTS && vec_mem[6 * num_tests][7:0] >= 8'd1
               && vec_mem[6 * num_tests][7:0] <= 8'd5)
            num_tests++;
        cycle_limit = num_tests * TEST_CYCLES;
        repeat (10) step();
        i_reset = 1'b0;
        repeat (5) step();               // Idle, nothing may start
        for (int t = 0; t < num_tests; t++)
            run_test(t);
        repeat (4) step();
        $display("Summary: %0d of %0d tests run, %0d failed, %0d errors",
                 tests_run, num_tests, tests_failed, error_count);
        if (num_tests > 0 && tests_run == num_tests && tests_failed == 0 && error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
